/* files.f */
soc_pkg.sv
ahbl_splitter.sv
ahbl_to_apb.sv
ahb_sync_sram.sv
uart_mini.sv
example_soc.sv
example_soc_assert.sv
tb_example_soc.sv

/* run.sh */
#!/bin/sh
# Build and run the example SoC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_example_soc -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

/* tb_example_soc.sv */
// Example SoC testbench
`timescale 1ns/1ps

module tb_example_soc;

	import soc_pkg::*;

	// Sequence takes roughly 1000 cycles including six UART frames
	localparam int MAX_CYCLES = 20000;
	// Baud divider for the loopback tests, each bit lasts DIV+1 cycles
	localparam int BAUD_DIV   = 7;
	localparam int BIT_CYCLES = BAUD_DIV + 1;

	logic        clk;
	logic        arst_n;
	logic [31:0] ahb_haddr;
	logic        ahb_hwrite;
	logic [1:0]  ahb_htrans;
	logic [2:0]  ahb_hsize;
	logic [31:0] ahb_hwdata;
	logic        ahb_hready;
	logic        ahb_hresp;
	logic [31:0] ahb_hrdata;
	logic        uart_irq;
	// TX looped back into RX
	wire         uart_line;

	int          seed = 55;
	int          cycles = 0;
	logic [7:0]  shadow [SRAM_DEPTH_WORDS*4];
	logic [31:0] exp_q [$];
	logic [7:0]  tx_exp_q [$];
	logic        rd_pending = 1'b0;

	example_soc example_soc_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.ahb_haddr  (ahb_haddr),
		.ahb_hwrite (ahb_hwrite),
		.ahb_htrans (ahb_htrans),
		.ahb_hsize  (ahb_hsize),
		.ahb_hwdata (ahb_hwdata),
		.ahb_hready (ahb_hready),
		.ahb_hresp  (ahb_hresp),
		.ahb_hrdata (ahb_hrdata),
		.uart_rx    (uart_line),
		.uart_tx    (uart_line),
		.uart_irq   (uart_irq)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("Run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test FAILED");
			$fatal(1);
		end
	end

	// -------------------------------------------------------------------------
	// Reference model and checks

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	// Word as the SRAM should hold it
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return {shadow[{addr[11:2], 2'd3}], shadow[{addr[11:2], 2'd2}],
			shadow[{addr[11:2], 2'd1}], shadow[{addr[11:2], 2'd0}]};
	endfunction

	// Each written lane takes its own hwdata byte
	function automatic logic [31:0] merged_word(input logic [31:0] old, input logic [1:0] offs,
		input logic [2:0] size, input logic [31:0] wdata);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (size == HSIZE_WORD || (size == HSIZE_HALF && b[1] == offs[1])
				|| (size == HSIZE_BYTE && b[1:0] == offs)) begin
				res[8*b +: 8] = wdata[8*b +: 8];
			end
		end
		return res;
	endfunction

	// Pairs each SRAM read data phase with its expected word
	always @(negedge clk) begin
		if (rd_pending && ahb_hready) begin
			check("ahb_hrdata", ahb_hrdata, exp_q.pop_front());
			rd_pending = 1'b0;
		end
		if (arst_n && ahb_hready && ahb_htrans == HTRANS_NONSEQ && !ahb_hwrite
			&& (ahb_haddr & REGION_MASK) == SRAM_BASE) begin
			rd_pending = 1'b1;
		end
	end

	// TX pin frame check, first low negedge is cycle 0 of the start bit
	initial begin
		logic [7:0] data;
		logic [7:0] exp_byte;
		forever begin
			@(negedge clk);
			if (arst_n === 1'b1 && uart_line === 1'b0) begin
				if (tx_exp_q.size() == 0) begin
					$display("TX frame started without a TX write");
					$display("Test FAILED");
					$fatal(1);
				end
				exp_byte = tx_exp_q.pop_front();
				// Sample every bit in its middle
				repeat (BIT_CYCLES / 2) @(negedge clk);
				check("uart_tx_start", 32'(uart_line), 32'h0);
				for (int b = 0; b < 8; b++) begin
					repeat (BIT_CYCLES) @(negedge clk);
					data[b] = uart_line;
				end
				repeat (BIT_CYCLES) @(negedge clk);
				check("uart_tx_stop", 32'(uart_line), 32'h1);
				check("uart_tx", 32'(data), 32'(exp_byte));
			end
		end
	end

	// -------------------------------------------------------------------------
	// Bus master

	// One NONSEQ transfer that returns at the negedge before its data phase ends
	task automatic transfer(input logic [31:0] addr, input logic write, input logic [2:0] size,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		ahb_haddr  <= addr;
		ahb_hwrite <= write;
		ahb_hsize  <= size;
		ahb_htrans <= HTRANS_NONSEQ;
		@(posedge clk);
		// Address and data held until hready
		ahb_htrans <= HTRANS_IDLE;
		ahb_hwdata <= wdata;
		@(negedge clk);
		while (!ahb_hready) begin
			@(negedge clk);
		end
		rdata = ahb_hrdata;
		err   = ahb_hresp;
	endtask

	task automatic store(input logic [31:0] addr, input logic [2:0] size,
		input logic [31:0] wdata);
		logic [31:0] word;
		logic [31:0] rd;
		logic        err;
		word = merged_word(word_at(addr), addr[1:0], size, wdata);
		for (int b = 0; b < 4; b++) begin
			shadow[{addr[11:2], b[1:0]}] = word[8*b +: 8];
		end
		transfer(addr, 1'b1, size, wdata, rd, err);
		check("ahb_hresp", 32'(err), 32'h0);
	endtask

	task automatic expect_read(input logic [31:0] addr);
		logic [31:0] rd;
		logic        err;
		exp_q.push_back(word_at(addr));
		transfer(addr, 1'b0, HSIZE_WORD, 32'h0, rd, err);
		check("ahb_hresp", 32'(err), 32'h0);
	endtask

	task automatic write_uart(input logic [15:0] offs, input logic [31:0] wdata,
		input logic exp_err);
		logic [31:0] rd;
		logic        err;
		transfer(UART_BASE | {16'h0, offs}, 1'b1, HSIZE_WORD, wdata, rd, err);
		check("ahb_hresp", 32'(err), 32'(exp_err));
	endtask

	task automatic read_uart(input logic [15:0] offs, output logic [31:0] rdata);
		logic err;
		transfer(UART_BASE | {16'h0, offs}, 1'b0, HSIZE_WORD, 32'h0, rdata, err);
		check("ahb_hresp", 32'(err), 32'h0);
	endtask

	task automatic poll_csr(input int pos, input logic value);
		logic [31:0] rd;
		read_uart(UART_CSR, rd);
		while (rd[pos] !== value) begin
			read_uart(UART_CSR, rd);
		end
	endtask

	// -------------------------------------------------------------------------
	// Test sequence

	initial begin
		logic [31:0] rd;
		logic [31:0] wdata;
		logic [31:0] base;
		logic [9:0]  idx;
		logic [7:0]  tx_byte;
		logic        err;
		logic [31:0] written [$];

		arst_n     = 1'b0;
		ahb_haddr  = '0;
		ahb_hwrite = 1'b0;
		ahb_htrans = HTRANS_IDLE;
		ahb_hsize  = HSIZE_WORD;
		ahb_hwdata = '0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;

		// Random word writes read back afterwards
		for (int i = 0; i < 64; i++) begin
			idx   = 10'($random(seed));
			wdata = $random(seed);
			store({20'h0, idx, 2'b00}, HSIZE_WORD, wdata);
			written.push_back({20'h0, idx, 2'b00});
		end
		foreach (written[i]) begin
			expect_read(written[i]);
		end

		// Byte and halfword lanes at every offset
		for (int n = 0; n < 4; n++) begin
			base = {20'h0, 10'($random(seed)), 2'b00};
			store(base, HSIZE_WORD, $random(seed));
			for (int off = 0; off < 4; off++) begin
				store(base + 32'(off), HSIZE_BYTE, $random(seed));
				expect_read(base);
			end
			for (int off = 0; off < 4; off += 2) begin
				store(base + 32'(off), HSIZE_HALF, $random(seed));
				expect_read(base);
			end
		end

		// Unmapped regions alias words 0 and 1 on a bad decode
		store(32'h0, HSIZE_WORD, $random(seed));
		store(32'h4, HSIZE_WORD, $random(seed));
		transfer(32'h2000_0000, 1'b1, HSIZE_WORD, 32'hdead_beef, rd, err);
		check("ahb_hresp", 32'(err), 32'h1);
		transfer(32'h8000_0004, 1'b1, HSIZE_WORD, 32'h1234_5678, rd, err);
		check("ahb_hresp", 32'(err), 32'h1);
		transfer(32'h8000_0000, 1'b0, HSIZE_WORD, 32'h0, rd, err);
		check("ahb_hresp", 32'(err), 32'h1);
		expect_read(32'h0);
		expect_read(32'h4);
		expect_read(written[0]);

		// UART registers after reset and DIV readback
		read_uart(UART_CSR, rd);
		check("uart_csr", rd, 32'h0);
		read_uart(UART_DIV, rd);
		check("uart_div", rd, 32'h0);
		wdata = {16'h0, 16'($random(seed))};
		write_uart(UART_DIV, wdata, 1'b0);
		read_uart(UART_DIV, rd);
		check("uart_div", rd, wdata);
		write_uart(UART_DIV, 32'(BAUD_DIV), 1'b0);

		// Loopback of four bytes
		write_uart(UART_CSR, 32'h1, 1'b0);
		for (int i = 0; i < 4; i++) begin
			tx_byte = 8'($random(seed));
			tx_exp_q.push_back(tx_byte);
			write_uart(UART_TX, {24'h0, tx_byte}, 1'b0);
			if (i == 0) begin
				// Second write while busy is dropped with an error
				read_uart(UART_CSR, rd);
				check("uart_csr_tx_busy", 32'(rd[CSR_TX_BUSY]), 32'h1);
				write_uart(UART_TX, 32'hff, 1'b1);
			end
			poll_csr(CSR_RX_VALID, 1'b1);
			read_uart(UART_RX, rd);
			check("uart_rx", rd, {24'h0, tx_byte});
			poll_csr(CSR_TX_BUSY, 1'b0);
		end

		// irq follows RX_VALID with IRQ_EN set
		write_uart(UART_CSR, 32'h3, 1'b0);
		tx_byte = 8'($random(seed));
		tx_exp_q.push_back(tx_byte);
		write_uart(UART_TX, {24'h0, tx_byte}, 1'b0);
		poll_csr(CSR_RX_VALID, 1'b1);
		check("uart_irq", 32'(uart_irq), 32'h1);
		read_uart(UART_RX, rd);
		check("uart_rx", rd, {24'h0, tx_byte});
		// irq is one register behind RX_VALID
		repeat (2) @(negedge clk);
		check("uart_irq", 32'(uart_irq), 32'h0);
		poll_csr(CSR_TX_BUSY, 1'b0);

		// Interrupt disabled
		write_uart(UART_CSR, 32'h1, 1'b0);
		tx_byte = 8'($random(seed));
		tx_exp_q.push_back(tx_byte);
		write_uart(UART_TX, {24'h0, tx_byte}, 1'b0);
		poll_csr(CSR_RX_VALID, 1'b1);
		check("uart_irq", 32'(uart_irq), 32'h0);
		read_uart(UART_RX, rd);
		check("uart_rx", rd, {24'h0, tx_byte});
		check("uart_irq", 32'(uart_irq), 32'h0);

		// Let the compare process drain the last read
		repeat (4) @(posedge clk);
		if (exp_q.size() != 0 || tx_exp_q.size() != 0) begin
			$display("SRAM reads or TX frames left unchecked");
			$display("Test FAILED");
			$fatal(1);
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

/* example_soc_assert.sv */
// Example SoC protocol assertions
`timescale 1ns/1ps

module example_soc_assert (
	input logic clk,
	input logic arst_n,
	input logic ahb_hready,
	input logic ahb_hresp,
	input logic uart_tx,
	input logic uart_psel,
	input logic uart_penable
);

	// APB setup cycle always moves on to access
	setup_then_access: assert property (@(posedge clk) disable iff (!arst_n)
		uart_psel && !uart_penable |=> uart_psel && uart_penable)
		else $error("APB setup cycle not followed by access");

	// Error response opens with hready low
	err_first_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ahb_hresp) |-> !ahb_hready)
		else $error("AHB error response started with hready high");

	// Then closes with hresp still high and hready high
	err_second_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		ahb_hresp && !ahb_hready |=> ahb_hresp && ahb_hready)
		else $error("AHB error response did not last two cycles");

	// Bus ready and serial line idle right after reset
	idle_after_reset: assert property (@(posedge clk)
		$rose(arst_n) |-> ahb_hready && uart_tx)
		else $error("Bus or UART line not idle after reset");

endmodule

bind example_soc example_soc_assert assert_i (
	.clk          (clk),
	.arst_n       (arst_n),
	.ahb_hready   (ahb_hready),
	.ahb_hresp    (ahb_hresp),
	.uart_tx      (uart_tx),
	.uart_psel    (uart_psel),
	.uart_penable (uart_penable)
);

/* example_soc.sv */
// Example SoC bus fabric and peripherals
`timescale 1ns/1ps

module example_soc (
	input  logic                       clk,
	input  logic                       arst_n,

	// AHB-Lite master port
	input  logic [soc_pkg::W_ADDR-1:0] ahb_haddr,
	input  logic                       ahb_hwrite,
	input  logic [1:0]                 ahb_htrans,
	input  logic [2:0]                 ahb_hsize,
	input  logic [soc_pkg::W_DATA-1:0] ahb_hwdata,
	output logic                       ahb_hready,
	output logic                       ahb_hresp,
	output logic [soc_pkg::W_DATA-1:0] ahb_hrdata,

	// UART pins
	input  logic                       uart_rx,
	output logic                       uart_tx,
	output logic                       uart_irq
);

	import soc_pkg::*;

	// -------------------------------------------------------------------------
	// AHB-Lite layer

	logic [W_ADDR-1:0]  dst_haddr;
	logic               dst_hwrite;
	logic [2:0]         dst_hsize;
	logic [W_DATA-1:0]  dst_hwdata;
	logic               dst_hready;
	logic [1:0]         sram_htrans;
	logic               sram_hready_resp;
	logic               sram_hresp;
	logic [W_DATA-1:0]  sram_hrdata;
	logic [1:0]         apb_htrans;
	logic               apb_hready_resp;
	logic               apb_hresp;
	logic [W_DATA-1:0]  apb_hrdata;

	ahbl_splitter splitter_i (
		.clk              (clk),
		.arst_n           (arst_n),
		.src_haddr        (ahb_haddr),
		.src_hwrite       (ahb_hwrite),
		.src_htrans       (ahb_htrans),
		.src_hsize        (ahb_hsize),
		.src_hwdata       (ahb_hwdata),
		.src_hready       (ahb_hready),
		.src_hresp        (ahb_hresp),
		.src_hrdata       (ahb_hrdata),
		.dst_haddr        (dst_haddr),
		.dst_hwrite       (dst_hwrite),
		.dst_hsize        (dst_hsize),
		.dst_hwdata       (dst_hwdata),
		.dst_hready       (dst_hready),
		.sram_htrans      (sram_htrans),
		.sram_hready_resp (sram_hready_resp),
		.sram_hresp       (sram_hresp),
		.sram_hrdata      (sram_hrdata),
		.apb_htrans       (apb_htrans),
		.apb_hready_resp  (apb_hready_resp),
		.apb_hresp        (apb_hresp),
		.apb_hrdata       (apb_hrdata)
	);

	// SRAM at region 0
	ahb_sync_sram #(
		.DEPTH (SRAM_DEPTH_WORDS)
	) sram_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.haddr       (dst_haddr),
		.hwrite      (dst_hwrite),
		.htrans      (sram_htrans),
		.hsize       (dst_hsize),
		.hready      (dst_hready),
		.hwdata      (dst_hwdata),
		.hready_resp (sram_hready_resp),
		.hresp       (sram_hresp),
		.hrdata      (sram_hrdata)
	);

	// -------------------------------------------------------------------------
	// APB layer

	logic [W_PADDR-1:0] uart_paddr;
	logic               uart_psel;
	logic               uart_penable;
	logic               uart_pwrite;
	logic [W_DATA-1:0]  uart_pwdata;
	logic [W_DATA-1:0]  uart_prdata;
	logic               uart_pready;
	logic               uart_pslverr;

	ahbl_to_apb bridge_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.haddr       (dst_haddr),
		.hwrite      (dst_hwrite),
		.htrans      (apb_htrans),
		.hready      (dst_hready),
		.hwdata      (dst_hwdata),
		.hready_resp (apb_hready_resp),
		.hresp       (apb_hresp),
		.hrdata      (apb_hrdata),
		.paddr       (uart_paddr),
		.psel        (uart_psel),
		.penable     (uart_penable),
		.pwrite      (uart_pwrite),
		.pwdata      (uart_pwdata),
		.prdata      (uart_prdata),
		.pready      (uart_pready),
		.pslverr     (uart_pslverr)
	);

	uart_mini uart_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.psel    (uart_psel),
		.penable (uart_penable),
		.pwrite  (uart_pwrite),
		.paddr   (uart_paddr),
		.pwdata  (uart_pwdata),
		.prdata  (uart_prdata),
		.pready  (uart_pready),
		.pslverr (uart_pslverr),
		.rx      (uart_rx),
		.tx      (uart_tx),
		.irq     (uart_irq)
	);

endmodule

/* uart_mini.sv */
// Minimal APB UART
`timescale 1ns/1ps

module uart_mini (
	input  logic                        clk,
	input  logic                        arst_n,

	// APB target
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [soc_pkg::W_PADDR-1:0] paddr,
	input  logic [soc_pkg::W_DATA-1:0]  pwdata,
	output logic [soc_pkg::W_DATA-1:0]  prdata,
	output logic                        pready,
	output logic                        pslverr,

	// Serial line and interrupt
	input  logic                        rx,
	output logic                        tx,
	output logic                        irq
);

	import soc_pkg::*;

	logic             apb_wr;
	logic             apb_rd;
	logic             tx_start;
	logic             rd_rx;
	// Control registers
	logic             en;
	logic             irq_en;
	logic [W_DIV-1:0] div;
	// Transmitter
	logic             tx_busy;
	logic [9:0]       tx_shift;
	logic [3:0]       tx_bit_cnt;
	logic [W_DIV-1:0] tx_div_cnt;
	// Receiver
	logic             rx_s1;
	logic             rx_s2;
	logic             rx_busy;
	logic [3:0]       rx_bit_cnt;
	logic [W_DIV-1:0] rx_div_cnt;
	logic             rx_tick;
	logic [7:0]       rx_shift;
	logic [7:0]       rx_hold;
	logic             rx_valid;

	// -------------------------------------------------------------------------
	// Register access

	assign apb_wr   = psel && penable && pwrite;
	assign apb_rd   = psel && penable && !pwrite;
	assign tx_start = apb_wr && paddr == UART_TX && !tx_busy && en;
	assign rd_rx    = apb_rd && paddr == UART_RX;
	assign pready   = 1'b1;
	// TX write while a frame is going out is dropped
	assign pslverr  = apb_wr && paddr == UART_TX && tx_busy;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			en     <= 1'b0;
			irq_en <= 1'b0;
			div    <= '0;
		end else if (apb_wr && paddr == UART_CSR) begin
			en     <= pwdata[CSR_EN];
			irq_en <= pwdata[CSR_IRQ_EN];
		end else if (apb_wr && paddr == UART_DIV) begin
			div <= pwdata[W_DIV-1:0];
		end
	end

	always_comb begin
		prdata = '0;
		case (paddr)
			UART_CSR: begin
				prdata[CSR_EN]       = en;
				prdata[CSR_IRQ_EN]   = irq_en;
				prdata[CSR_TX_BUSY]  = tx_busy;
				prdata[CSR_RX_VALID] = rx_valid;
			end
			UART_DIV: prdata[W_DIV-1:0] = div;
			UART_RX:  prdata[7:0] = rx_hold;
			default:  prdata = '0;
		endcase
	end

	// -------------------------------------------------------------------------
	// Transmitter

	// Frame is stop, data, start and shifts out from bit 0
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_busy    <= 1'b0;
			tx_shift   <= '1;
			tx_bit_cnt <= '0;
			tx_div_cnt <= '0;
		end else if (tx_start) begin
			tx_busy    <= 1'b1;
			tx_shift   <= {1'b1, pwdata[7:0], 1'b0};
			tx_bit_cnt <= '0;
			tx_div_cnt <= div;
		end else if (tx_busy) begin
			if (tx_div_cnt == '0) begin
				// Bit period over, each lasts div+1 cycles
				tx_div_cnt <= div;
				tx_shift   <= {1'b1, tx_shift[9:1]};
				tx_bit_cnt <= tx_bit_cnt + 4'd1;
				if (tx_bit_cnt == 4'd9) begin
					tx_busy <= 1'b0;
				end
			end else begin
				tx_div_cnt <= tx_div_cnt - W_DIV'(1);
			end
		end
	end

	assign tx = tx_shift[0];

	// -------------------------------------------------------------------------
	// Receiver

	assign rx_tick = rx_busy && rx_div_cnt == '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_s1      <= 1'b1;
			rx_s2      <= 1'b1;
			rx_busy    <= 1'b0;
			rx_bit_cnt <= '0;
			rx_div_cnt <= '0;
			rx_valid   <= 1'b0;
			irq        <= 1'b0;
		end else begin
			rx_s1 <= rx;
			rx_s2 <= rx_s1;
			irq   <= rx_valid && irq_en;
			if (rd_rx) begin
				rx_valid <= 1'b0;
			end
			if (!rx_busy) begin
				// Start bit seen, first sample lands mid-bit
				if (en && !rx_s2) begin
					rx_busy    <= 1'b1;
					rx_bit_cnt <= '0;
					rx_div_cnt <= div >> 1;
				end
			end else if (!rx_tick) begin
				rx_div_cnt <= rx_div_cnt - W_DIV'(1);
			end else begin
				rx_div_cnt <= div;
				rx_bit_cnt <= rx_bit_cnt + 4'd1;
				if (rx_bit_cnt == 4'd0 && rx_s2) begin
					// Glitch, not a real start bit
					rx_busy <= 1'b0;
				end else if (rx_bit_cnt == 4'd9) begin
					rx_busy <= 1'b0;
					// Byte only kept with a valid stop bit
					if (rx_s2) begin
						rx_valid <= 1'b1;
					end
				end
			end
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk) begin
		if (rx_tick && rx_bit_cnt != 4'd0 && rx_bit_cnt != 4'd9) begin
			rx_shift <= {rx_s2, rx_shift[7:1]};
		end
		if (rx_tick && rx_bit_cnt == 4'd9 && rx_s2) begin
			rx_hold <= rx_shift;
		end
	end

endmodule

/* ahb_sync_sram.sv */
// Zero-wait AHB-Lite SRAM
`timescale 1ns/1ps

module ahb_sync_sram #(
	parameter int DEPTH = soc_pkg::SRAM_DEPTH_WORDS
) (
	input  logic                        clk,
	input  logic                        arst_n,

	input  logic [soc_pkg::W_ADDR-1:0]  haddr,
	input  logic                        hwrite,
	input  logic [1:0]                  htrans,
	input  logic [2:0]                  hsize,
	input  logic                        hready,
	input  logic [soc_pkg::W_DATA-1:0]  hwdata,
	output logic                        hready_resp,
	output logic                        hresp,
	output logic [soc_pkg::W_DATA-1:0]  hrdata
);

	import soc_pkg::*;

	logic [W_DATA-1:0]        mem [DEPTH];
	logic [W_DATA-1:0]        rdata_q;
	logic                     aphase;
	logic [$clog2(DEPTH)-1:0] ap_idx;
	logic [W_DATA/8-1:0]      ap_be;
	// Registered address phase
	logic                     dp_write;
	logic [$clog2(DEPTH)-1:0] dp_idx;
	logic [W_DATA/8-1:0]      dp_be;
	logic                     wr_en;

	assign aphase = hready && htrans == HTRANS_NONSEQ;
	assign ap_idx = haddr[$clog2(DEPTH)+1:2];
	assign wr_en  = dp_write && hready;

	// Byte lanes from size and low address bits
	always_comb begin
		case (hsize)
			HSIZE_BYTE: ap_be = 4'b0001 << haddr[1:0];
			HSIZE_HALF: ap_be = 4'b0011 << {haddr[1], 1'b0};
			HSIZE_WORD: ap_be = 4'b1111;
			default:    ap_be = 4'b1111;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dp_write <= 1'b0;
		end else if (hready) begin
			dp_write <= aphase && hwrite;
		end
	end

	always_ff @(posedge clk) begin
		if (hready && aphase) begin
			dp_idx <= ap_idx;
			dp_be  <= ap_be;
		end
	end

	// Array write and read with same-word bypass
	always_ff @(posedge clk) begin
		for (int i = 0; i < W_DATA / 8; i++) begin
			if (wr_en && dp_be[i]) begin
				mem[dp_idx][8*i +: 8] <= hwdata[8*i +: 8];
			end
			if (aphase) begin
				// A write finishing on this edge is not yet in the array
				if (wr_en && dp_be[i] && dp_idx == ap_idx) begin
					rdata_q[8*i +: 8] <= hwdata[8*i +: 8];
				end else begin
					rdata_q[8*i +: 8] <= mem[ap_idx][8*i +: 8];
				end
			end
		end
	end

	assign hrdata      = rdata_q;
	assign hready_resp = 1'b1;
	assign hresp       = 1'b0;

endmodule

/* ahbl_to_apb.sv */
// AHB-Lite to APB bridge
`timescale 1ns/1ps

module ahbl_to_apb (
	input  logic                        clk,
	input  logic                        arst_n,

	// AHB-Lite target side
	input  logic [soc_pkg::W_ADDR-1:0]  haddr,
	input  logic                        hwrite,
	input  logic [1:0]                  htrans,
	input  logic                        hready,
	input  logic [soc_pkg::W_DATA-1:0]  hwdata,
	output logic                        hready_resp,
	output logic                        hresp,
	output logic [soc_pkg::W_DATA-1:0]  hrdata,

	// APB requester side
	output logic [soc_pkg::W_PADDR-1:0] paddr,
	output logic                        psel,
	output logic                        penable,
	output logic                        pwrite,
	output logic [soc_pkg::W_DATA-1:0]  pwdata,
	input  logic [soc_pkg::W_DATA-1:0]  prdata,
	input  logic                        pready,
	input  logic                        pslverr
);

	import soc_pkg::*;

	logic [W_BR_STATE-1:0] state;
	logic                  aphase;

	assign aphase = hready && htrans == HTRANS_NONSEQ;

	// -------------------------------------------------------------------------
	// Transfer FSM

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= BR_IDLE;
		end else begin
			case (state)
				// Idle and the error tail can both accept a new address phase
				BR_IDLE, BR_ERR2: begin
					state <= aphase ? BR_SETUP : BR_IDLE;
				end
				BR_SETUP: begin
					state <= BR_ACCESS;
				end
				BR_ACCESS: begin
					if (pready) begin
						state <= pslverr ? BR_ERR1 : BR_IDLE;
					end
				end
				BR_ERR1: begin
					state <= BR_ERR2;
				end
				default: begin
					state <= BR_IDLE;
				end
			endcase
		end
	end

	// Address and direction held from setup to completion
	always_ff @(posedge clk) begin
		if ((state == BR_IDLE || state == BR_ERR2) && aphase) begin
			paddr  <= haddr[W_PADDR-1:0];
			pwrite <= hwrite;
		end
	end

	// Read data returned on the cycle after pready
	always_ff @(posedge clk) begin
		if (state == BR_ACCESS && pready) begin
			hrdata <= prdata;
		end
	end

	// -------------------------------------------------------------------------
	// Outputs decoded from state

	assign psel        = state == BR_SETUP || state == BR_ACCESS;
	assign penable     = state == BR_ACCESS;
	assign hready_resp = state == BR_IDLE || state == BR_ERR2;
	assign hresp       = state == BR_ERR1 || state == BR_ERR2;

	// Master holds hwdata for the whole data phase
	assign pwdata = hwdata;

endmodule

/* ahbl_splitter.sv */
// AHB-Lite address splitter
`timescale 1ns/1ps

module ahbl_splitter (
	input  logic                        clk,
	input  logic                        arst_n,

	// Upstream master
	input  logic [soc_pkg::W_ADDR-1:0]  src_haddr,
	input  logic                        src_hwrite,
	input  logic [1:0]                  src_htrans,
	input  logic [2:0]                  src_hsize,
	input  logic [soc_pkg::W_DATA-1:0]  src_hwdata,
	output logic                        src_hready,
	output logic                        src_hresp,
	output logic [soc_pkg::W_DATA-1:0]  src_hrdata,

	// Shared downstream request
	output logic [soc_pkg::W_ADDR-1:0]  dst_haddr,
	output logic                        dst_hwrite,
	output logic [2:0]                  dst_hsize,
	output logic [soc_pkg::W_DATA-1:0]  dst_hwdata,
	output logic                        dst_hready,

	// SRAM target
	output logic [1:0]                  sram_htrans,
	input  logic                        sram_hready_resp,
	input  logic                        sram_hresp,
	input  logic [soc_pkg::W_DATA-1:0]  sram_hrdata,

	// APB bridge target
	output logic [1:0]                  apb_htrans,
	input  logic                        apb_hready_resp,
	input  logic                        apb_hresp,
	input  logic [soc_pkg::W_DATA-1:0]  apb_hrdata
);

	import soc_pkg::*;

	logic sel_sram;
	logic sel_apb;
	logic aphase;
	// Owner of the current data phase, at most one set
	logic dp_sram;
	logic dp_apb;
	logic dp_err;
	// Second cycle of an error response
	logic err_second;

	// -------------------------------------------------------------------------
	// Address phase decode

	assign sel_sram = (src_haddr & REGION_MASK) == SRAM_BASE;
	assign sel_apb  = (src_haddr & REGION_MASK) == UART_BASE;
	assign aphase   = src_hready && src_htrans == HTRANS_NONSEQ;

	// Request fields are shared, only htrans is steered
	assign dst_haddr   = src_haddr;
	assign dst_hwrite  = src_hwrite;
	assign dst_hsize   = src_hsize;
	assign dst_hwdata  = src_hwdata;
	assign dst_hready  = src_hready;
	assign sram_htrans = sel_sram ? src_htrans : HTRANS_IDLE;
	assign apb_htrans  = sel_apb ? src_htrans : HTRANS_IDLE;

	// -------------------------------------------------------------------------
	// Data phase ownership

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dp_sram    <= 1'b0;
			dp_apb     <= 1'b0;
			dp_err     <= 1'b0;
			err_second <= 1'b0;
		end else if (src_hready) begin
			// New owner taken only when the previous data phase ends
			dp_sram    <= aphase && sel_sram;
			dp_apb     <= aphase && sel_apb;
			dp_err     <= aphase && !sel_sram && !sel_apb;
			err_second <= 1'b0;
		end else if (dp_err) begin
			err_second <= 1'b1;
		end
	end

	// Response steering back to the master
	always_comb begin
		if (dp_err) begin
			src_hready = err_second;
			src_hresp  = 1'b1;
		end else if (dp_sram) begin
			src_hready = sram_hready_resp;
			src_hresp  = sram_hresp;
		end else if (dp_apb) begin
			src_hready = apb_hready_resp;
			src_hresp  = apb_hresp;
		end else begin
			// No transfer in flight
			src_hready = 1'b1;
			src_hresp  = 1'b0;
		end
	end

	assign src_hrdata = dp_apb ? apb_hrdata : sram_hrdata;

endmodule

/* soc_pkg.sv */
// Example SoC shared definitions
package soc_pkg;

	// Bus widths
	localparam int W_ADDR  = 32;
	localparam int W_DATA  = 32;
	localparam int W_PADDR = 16;
	localparam int W_DIV   = 16;

	// Address map, regions are decoded on the top three bits
	localparam logic [W_ADDR-1:0] SRAM_BASE   = 32'h0000_0000;
	localparam logic [W_ADDR-1:0] UART_BASE   = 32'h4000_0000;
	localparam logic [W_ADDR-1:0] REGION_MASK = 32'he000_0000;

	localparam int SRAM_DEPTH_WORDS = 1024;

	// AHB-Lite transfer type and size codes
	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

	localparam logic [2:0] HSIZE_BYTE = 3'b000;
	localparam logic [2:0] HSIZE_HALF = 3'b001;
	localparam logic [2:0] HSIZE_WORD = 3'b010;

	// UART register offsets
	localparam logic [W_PADDR-1:0] UART_CSR = 16'h0;
	localparam logic [W_PADDR-1:0] UART_DIV = 16'h4;
	localparam logic [W_PADDR-1:0] UART_TX  = 16'h8;
	localparam logic [W_PADDR-1:0] UART_RX  = 16'hc;

	// CSR fields, busy and valid are read-only
	localparam int CSR_EN       = 0;
	localparam int CSR_IRQ_EN   = 1;
	localparam int CSR_TX_BUSY  = 8;
	localparam int CSR_RX_VALID = 9;

	// APB bridge FSM states
	localparam int W_BR_STATE = 3;
	localparam logic [W_BR_STATE-1:0] BR_IDLE   = 3'd0;
	localparam logic [W_BR_STATE-1:0] BR_SETUP  = 3'd1;
	localparam logic [W_BR_STATE-1:0] BR_ACCESS = 3'd2;
	localparam logic [W_BR_STATE-1:0] BR_ERR1   = 3'd3;
	localparam logic [W_BR_STATE-1:0] BR_ERR2   = 3'd4;

endpackage
